//--- axis_consts.svh
/*
  stream geometry for the traffic loop
  data width must be a whole number of bytes and keep is always full
  beat and packet counts must fit in AXIS_CNT_W bits
*/
`ifndef AXIS_CONSTS_SVH
`define AXIS_CONSTS_SVH

// payload width in bits
`define AXIS_DATA_W 64

// one keep bit per byte lane
`define AXIS_KEEP_W (`AXIS_DATA_W / 8)

// beats in one packet, tlast sits on the final one
`define AXIS_PKT_BEATS 16

// packets in one loop before loop_done
`define AXIS_LOOP_PKTS 12

// width of beat, packet and received-packet counters
`define AXIS_CNT_W 16

`endif

//--- axis_gen_checker.sv
/*
  stream sink that checks the generator's byte-count pattern
  tready follows sink_ready_i directly
  only the first error is kept, the packet count saturates
*/
`timescale 1ns/1ns
`include "axis_consts.svh"

module axis_gen_checker
  import axis_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  axis_mosi_s             bus_i,
  output axis_miso_s             bus_o,
  input  logic                   sink_ready_i,
  output logic [`AXIS_CNT_W-1:0] pkts_rcvd_o,
  output logic                   err_o,
  output chk_err_e               err_kind_o
);

  localparam logic [`AXIS_CNT_W-1:0] last_beat_lp = `AXIS_PKT_BEATS - 1;
  localparam logic [`AXIS_KEEP_W-1:0] full_keep_lp = '1;

  logic [7:0]             exp_byte_q;  // byte expected on every lane
  logic [`AXIS_CNT_W-1:0] beat_q;      // expected beat index
  logic [`AXIS_CNT_W-1:0] pkts_q;
  logic                   err_q;
  chk_err_e               err_kind_q;

  logic                   xfer;
  logic                   exp_last;
  logic [`AXIS_DATA_W-1:0] exp_data;
  chk_err_e               hit_kind;    // mismatch class of the current beat

  assign bus_o.tready = sink_ready_i;
  assign xfer         = bus_i.tvalid & sink_ready_i;

  assign exp_data = {`AXIS_KEEP_W{exp_byte_q}};
  assign exp_last = (beat_q == last_beat_lp);

  assign pkts_rcvd_o = pkts_q;
  assign err_o       = err_q;
  assign err_kind_o  = err_kind_q;

  // data outranks keep, keep outranks tlast
  always_comb begin
    hit_kind = ERR_NONE;
    if (bus_i.tdata != exp_data) begin
      hit_kind = ERR_DATA;
    end else if (bus_i.tkeep != full_keep_lp) begin
      hit_kind = ERR_KEEP;
    end else if (bus_i.tlast != exp_last) begin
      hit_kind = ERR_LAST;
    end
  end

  // expectation tracking
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exp_byte_q <= 8'h00;
      beat_q     <= '0;
    end else if (xfer) begin
      exp_byte_q <= exp_byte_q + 8'h01;
      beat_q     <= exp_last ? '0 : beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pkts_q <= '0;
    end else if (xfer && bus_i.tlast && (pkts_q != '1)) begin
      pkts_q <= pkts_q + 1'b1; // holds at all ones
    end
  end

  // sticky error
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q      <= 1'b0;
      err_kind_q <= ERR_NONE;
    end else if (xfer && !err_q && (hit_kind != ERR_NONE)) begin
      err_q      <= 1'b1;
      err_kind_q <= hit_kind;
    end
  end

endmodule

//--- axis_gen_master.sv
/*
  stream generator that counts bytes on every lane
  a new loop needs en_i low then high again after loop_done_o
  the byte counter carries across loops and pauses
*/
`timescale 1ns/1ns
`include "axis_consts.svh"

module axis_gen_master
  import axis_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       en_i,
  input  axis_miso_s bus_i,
  output axis_mosi_s bus_o,
  output logic       loop_done_o
);

  localparam logic [`AXIS_CNT_W-1:0] last_beat_lp = `AXIS_PKT_BEATS - 1;
  localparam logic [`AXIS_CNT_W-1:0] last_pkt_lp  = `AXIS_LOOP_PKTS - 1;

  gen_state_e             state_q;
  gen_state_e             state_d;
  logic                   armed_q;     // en_i has been low since the last loop
  logic [`AXIS_CNT_W-1:0] beat_cnt_q;  // beat index inside the packet
  logic [`AXIS_CNT_W-1:0] pkt_cnt_q;   // packet index inside the loop
  logic [7:0]             byte_q;
  logic                   loop_done_q;

  logic transfer;
  logic last_beat;
  logic last_pkt;
  logic loop_end;

  assign transfer  = bus_o.tvalid & bus_i.tready;
  assign last_beat = (beat_cnt_q == last_beat_lp);
  assign last_pkt  = (pkt_cnt_q == last_pkt_lp);
  assign loop_end  = transfer & last_beat & last_pkt;

  // everything below is a function of registers, so it holds until the transfer
  assign bus_o.tvalid = (state_q != GEN_IDLE);
  assign bus_o.tdata  = {`AXIS_KEEP_W{byte_q}};
  assign bus_o.tkeep  = '1;
  assign bus_o.tlast  = last_beat;

  assign loop_done_o = loop_done_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      GEN_IDLE: begin
        if (en_i && armed_q) begin
          state_d = GEN_STREAM;
        end
      end
      GEN_STREAM: begin
        if (loop_end) begin
          state_d = GEN_IDLE;
        end else if (!en_i) begin
          state_d = transfer ? GEN_IDLE : GEN_DRAIN; // pending beat must still go out
        end
      end
      GEN_DRAIN: begin
        if (transfer) begin
          state_d = GEN_IDLE;
        end
      end
      default: state_d = GEN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= GEN_IDLE;
      armed_q     <= 1'b1;
      loop_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      loop_done_q <= loop_end;
      if (loop_end) begin
        armed_q <= 1'b0;
      end else if (!en_i) begin
        armed_q <= 1'b1;
      end
    end
  end

  // position counters, advanced only on accepted beats
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_cnt_q <= '0;
      pkt_cnt_q  <= '0;
      byte_q     <= 8'h00;
    end else if (transfer) begin
      byte_q <= byte_q + 8'h01; // wraps at 256
      if (last_beat) begin
        beat_cnt_q <= '0;
        pkt_cnt_q  <= last_pkt ? '0 : pkt_cnt_q + 1'b1;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- axis_loop_tb.sv
/*
  directed testbench for the generator, skid buffer and checker loop
  inputs are driven and outputs sampled on the falling clock edge
  the run stops at the first mismatch, a watchdog bounds its length
*/
`timescale 1ns/1ns
`include "axis_consts.svh"

module axis_loop_tb
  import axis_pkg::*;
();

  localparam int clk_period_lp = 40;
  localparam int loop_pkts_lp  = `AXIS_LOOP_PKTS;
  localparam int drain_lp      = 8;   // covers the buffer entries and the checker flop
  // four loops at one ready in four cycles, plus reset, pauses and idle windows
  localparam longint watchdog_ns_lp =
    longint'(4 * `AXIS_PKT_BEATS * `AXIS_LOOP_PKTS * 4 * clk_period_lp) +
    longint'(2000 * clk_period_lp);

  logic                   clk;
  logic                   rst;
  logic                   en;
  logic                   sink_ready;
  logic                   loop_done;
  logic [`AXIS_CNT_W-1:0] pkts_rcvd;
  logic                   err;
  chk_err_e               err_kind;
  int                     done_cnt;   // loop_done pulses seen so far

  axis_loop_top axis_loop_top_i (
    .clk_i        (clk),
    .reset_i      (rst),
    .en_i         (en),
    .sink_ready_i (sink_ready),
    .loop_done_o  (loop_done),
    .pkts_rcvd_o  (pkts_rcvd),
    .err_o        (err),
    .err_kind_o   (err_kind)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  // counted on the rising edge that ends the pulse
  always @(posedge clk) begin
    if (rst) begin
      done_cnt <= 0;
    end else if (loop_done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  initial begin
    #(watchdog_ns_lp);
    $display("watchdog expired, the run timed out before all tests finished");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  task automatic check_eq(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("mismatch %s expected %0d actual %0d", name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  function automatic logic rand_ready();
    return ($urandom() & 32'd1) != 32'd0;
  endfunction

  // en_i low for one cycle, then high, to arm a new loop
  task automatic restart_loop();
    en = 1'b0;
    @(negedge clk);
    en = 1'b1;
  endtask

  task automatic wait_loop_done(input logic use_rand);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      if (loop_done) begin
        seen = 1'b1;
      end else if (use_rand) begin
        sink_ready = rand_ready();
      end
    end
  endtask

  task automatic wait_pkts(input int target);
    while (int'(pkts_rcvd) < target) begin
      @(negedge clk);
    end
  endtask

  // counters and flags must hold still for a number of cycles
  task automatic hold_check(input string name, input int cycles, input int pkts,
                            input int dones);
    repeat (cycles) begin
      @(negedge clk);
      check_eq({name, " pkts_rcvd"}, pkts, pkts_rcvd);
      check_eq({name, " loop_done count"}, dones, done_cnt);
      check_eq({name, " err"}, 0, err);
    end
  endtask

  task automatic test_reset_state();
    repeat (20) begin
      @(negedge clk);
      check_eq("test_reset_state loop_done", 0, loop_done);
      check_eq("test_reset_state err", 0, err);
      check_eq("test_reset_state pkts_rcvd", 0, pkts_rcvd);
    end
  endtask

  task automatic test_full_rate_loop();
    sink_ready = 1'b1;
    en = 1'b1;
    wait_loop_done(1'b0);
    wait_pkts(loop_pkts_lp);
    hold_check("test_full_rate_loop", drain_lp, loop_pkts_lp, 1);
    check_eq("test_full_rate_loop err_kind", int'(ERR_NONE), int'(err_kind));
  endtask

  task automatic test_backpressure();
    restart_loop();
    wait_loop_done(1'b1);
    sink_ready = 1'b1;
    wait_pkts(2 * loop_pkts_lp);
    hold_check("test_backpressure", drain_lp, 2 * loop_pkts_lp, 2);
  endtask

  task automatic test_enable_pause();
    int pause_len;
    pause_len = 16 + int'($urandom() % 32);
    restart_loop();
    // let a few packets through before the pause
    while (int'(pkts_rcvd) < 2 * loop_pkts_lp + 4) begin
      @(negedge clk);
      sink_ready = rand_ready();
    end
    en = 1'b0;
    sink_ready = 1'b1;
    // beats still in flight open the next packet, so the count holds
    hold_check("test_enable_pause pause", drain_lp + pause_len,
               2 * loop_pkts_lp + 4, 2);
    en = 1'b1;
    wait_loop_done(1'b1);
    sink_ready = 1'b1;
    wait_pkts(3 * loop_pkts_lp);
    hold_check("test_enable_pause", drain_lp, 3 * loop_pkts_lp, 3);
  endtask

  task automatic test_no_restart_without_edge();
    // en stays high from the last test
    hold_check("test_no_restart_without_edge idle", `AXIS_PKT_BEATS * 4,
               3 * loop_pkts_lp, 3);
    restart_loop();
    wait_pkts(3 * loop_pkts_lp + 1);
    check_eq("test_no_restart_without_edge err", 0, err);
    check_eq("test_no_restart_without_edge err_kind", int'(ERR_NONE), int'(err_kind));
  endtask

  initial begin
    rst = 1'b1;
    en = 1'b0;
    sink_ready = 1'b0;
    void'($urandom(60712));
    repeat (16) @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_full_rate_loop();
    test_backpressure();
    test_enable_pause();
    test_no_restart_without_edge();
    $display("sim passed");
    $finish;
  end

endmodule

//--- axis_loop_top.sv
/*
  generator, skid buffer and checker in one loop
  sink_ready_i drives the checker's tready for outside back-pressure
*/
`timescale 1ns/1ns
`include "axis_consts.svh"

module axis_loop_top
  import axis_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   en_i,
  input  logic                   sink_ready_i,
  output logic                   loop_done_o,
  output logic [`AXIS_CNT_W-1:0] pkts_rcvd_o,
  output logic                   err_o,
  output chk_err_e               err_kind_o
);

  axis_mosi_s gen_bus;  // generator to buffer
  axis_miso_s gen_rdy;
  axis_mosi_s chk_bus;  // buffer to checker
  axis_miso_s chk_rdy;

  axis_gen_master gen_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .en_i        (en_i),
    .bus_i       (gen_rdy),
    .bus_o       (gen_bus),
    .loop_done_o (loop_done_o)
  );

  axis_skid_buffer skid_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .up_i     (gen_bus),
    .up_rdy_o (gen_rdy),
    .dn_o     (chk_bus),
    .dn_rdy_i (chk_rdy)
  );

  axis_gen_checker chk_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus_i        (chk_bus),
    .bus_o        (chk_rdy),
    .sink_ready_i (sink_ready_i),
    .pkts_rcvd_o  (pkts_rcvd_o),
    .err_o        (err_o),
    .err_kind_o   (err_kind_o)
  );

endmodule

//--- axis_pkg.sv
/*
  shared bus structs and enums for the stream loop
  tready is the only slave-to-master signal, no tuser/tid/tdest
*/
package axis_pkg;

`include "axis_consts.svh"

  // master to slave half of the stream bus
  typedef struct packed {
    logic [`AXIS_DATA_W-1:0] tdata;
    logic [`AXIS_KEEP_W-1:0] tkeep;
    logic                    tlast;
    logic                    tvalid;
  } axis_mosi_s;

  // slave to master half
  typedef struct packed {
    logic tready;
  } axis_miso_s;

  // generator control states
  typedef enum logic [1:0] {
    GEN_IDLE   = 2'd0, // no valid beat on the bus
    GEN_STREAM = 2'd1,
    GEN_DRAIN  = 2'd2  // en_i dropped with a beat still pending
  } gen_state_e;

  // first error seen by the checker
  typedef enum logic [1:0] {
    ERR_NONE = 2'd0,
    ERR_DATA = 2'd1, // a byte lane off the expected count
    ERR_KEEP = 2'd2,
    ERR_LAST = 2'd3  // tlast missing or misplaced
  } chk_err_e;

endpackage

//--- axis_skid_buffer.sv
/*
  two-entry register slice between master and slave
  upstream tready comes from a flop, so up_rdy_o has no path from dn_rdy_i
  full throughput with one cycle of latency when downstream is ready
*/
`timescale 1ns/1ns

module axis_skid_buffer
  import axis_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  axis_mosi_s up_i,
  output axis_miso_s up_rdy_o,
  output axis_mosi_s dn_o,
  input  axis_miso_s dn_rdy_i
);

  axis_mosi_s main_q; // beat presented downstream
  axis_mosi_s skid_q; // overflow when downstream stalls

  logic up_xfer;
  logic dn_xfer;

  // skid only fills when main is held, so a free skid means room for one
  assign up_rdy_o.tready = ~skid_q.tvalid;
  assign dn_o            = main_q;

  assign up_xfer = up_i.tvalid & up_rdy_o.tready;
  assign dn_xfer = main_q.tvalid & dn_rdy_i.tready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      main_q.tvalid <= 1'b0;
      skid_q.tvalid <= 1'b0;
    end else if (!main_q.tvalid || dn_xfer) begin
      // main frees up this cycle, oldest beat moves in first
      if (skid_q.tvalid) begin
        main_q        <= skid_q;
        skid_q.tvalid <= 1'b0;
      end else if (up_xfer) begin
        main_q <= up_i;
      end else begin
        main_q.tvalid <= 1'b0;
      end
    end else if (up_xfer) begin
      skid_q <= up_i; // main stalled, park the new beat
    end
  end

endmodule

//--- filelist.f
+incdir+.
axis_pkg.sv
axis_gen_master.sv
axis_skid_buffer.sv
axis_gen_checker.sv
axis_loop_top.sv
axis_loop_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the stream loop testbench with Verilator and runs it
# exit status is nonzero when the simulation stops on a $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -Wno-fatal \
  --top-module axis_loop_tb \
  -f filelist.f \
  -o axis_loop_sim

./obj_dir/axis_loop_sim
